// File: all.f
+incdir+include
src/pifo_pkg.sv
src/arrival_queue.sv
src/slot_arbiter.sv
src/context_mem.sv
src/dispatch_queue.sv
src/completion_merge.sv
src/egress_queue.sv
src/pifo.sv
test/pifo_props.sv
test/pifo_tb.sv

// File: include/pifo_settings.svh
`ifndef PIFO_SETTINGS_SVH
`define PIFO_SETTINGS_SVH

// in-flight packet slots
`define PIFO_SLOTS 8

// processing cores
`define PIFO_CONS 4

`define PIFO_PORTS 2      // output ports

// longest program a descriptor may carry
`define PIFO_STGS 3

`define PIFO_HNDL_W 16    // packet handle width

`define PIFO_AQ_DEPTH 4   // arrival fifo entries

`endif

// File: run.sh
#!/bin/sh
# build and run the pifo testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module pifo_tb -f all.f -o pifo_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/pifo_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "=== PASS ==="; then
  exit 0
fi
exit 1

// File: src/arrival_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "pifo_settings.svh"

module arrival_queue (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  ar_push,
  input  wire pifo_pkg::desc_t ar_dat,
  output logic                 ar_bp,
  output logic                 aq_vld,
  output pifo_pkg::desc_t      aq_desc,
  input  wire                  alloc
);

  localparam int DEPTH = `PIFO_AQ_DEPTH;
  localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  pifo_pkg::desc_t mem [DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [AW:0]     count;
  logic            push;

  assign ar_bp   = (count == (AW+1)'(DEPTH));  // full
  assign aq_vld  = (count != '0);
  assign aq_desc = mem[rd_ptr];
  assign push    = ar_push && !ar_bp;

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= ar_dat;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      if (alloc) rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      // alloc only follows aq_vld, so no underflow
      if (push && !alloc) count <= count + 1'b1;
      else if (!push && alloc) count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: src/completion_merge.sv
`timescale 1ns/1ps
`default_nettype none
`include "pifo_settings.svh"

module completion_merge (
  input  wire                               clk,
  input  wire                               rst_n,
  input  wire [`PIFO_CONS-1:0]              r_vld,
  input  wire pifo_pkg::ret_t [`PIFO_CONS-1:0] r_item,
  output logic [`PIFO_CONS-1:0]             r_bp,
  output logic                              cmpl_vld,
  output pifo_pkg::ret_t                    cmpl
);

  localparam int NC = `PIFO_CONS;

  pifo_pkg::ret_t  cap [NC];
  logic [NC-1:0]   full;
  pifo_pkg::cons_t rr_ptr;
  pifo_pkg::cons_t pick;

  assign r_bp = full;  // hold off while a return waits

  always_comb begin : merge_pick
    int idx;
    pick = rr_ptr;
    for (int i = NC - 1; i >= 0; i--) begin
      idx = (int'(rr_ptr) + i) % NC;
      if (full[idx]) pick = pifo_pkg::cons_t'(idx);
    end
  end

  assign cmpl_vld = |full;
  assign cmpl     = cap[pick];

  always_ff @(posedge clk) begin
    for (int c = 0; c < NC; c++) begin
      if (r_vld[c] && !full[c]) cap[c] <= r_item[c];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full   <= '0;
      rr_ptr <= '0;
    end else begin
      for (int c = 0; c < NC; c++) begin
        if (r_vld[c] && !full[c]) full[c] <= 1'b1;
        else if (cmpl_vld && (pick == pifo_pkg::cons_t'(c))) full[c] <= 1'b0;
      end
      if (cmpl_vld) rr_ptr <= (int'(pick) == NC - 1) ? '0 : pick + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: src/context_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "pifo_settings.svh"

module context_mem (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  alloc,
  input  wire pifo_pkg::slot_t alloc_slot,
  input  wire pifo_pkg::desc_t aq_desc,
  input  wire pifo_pkg::slot_t disp_slot,
  input  wire pifo_pkg::stg_t  disp_stg,
  output pifo_pkg::cons_t      disp_cons,
  output pifo_pkg::hndl_t      disp_hndl,
  input  wire                  cmpl_vld,
  input  wire pifo_pkg::ret_t  cmpl,
  input  wire pifo_pkg::slot_t retire_slot,
  output pifo_pkg::egr_t       retire_item,
  output pifo_pkg::port_t      retire_port,
  output pifo_pkg::stg_t       alloc_nstg
);

  localparam int NS = `PIFO_SLOTS;

  pifo_pkg::cons_t [`PIFO_STGS-1:0] prog_mem [NS];
  pifo_pkg::port_t                  port_mem [NS];
  pifo_pkg::hndl_t                  hndl_mem [NS];
  pifo_pkg::stg_t                   done [NS];

  // program and port are fixed for the life of the slot
  always_ff @(posedge clk) begin
    if (alloc) begin
      prog_mem[alloc_slot] <= aq_desc.prog;
      port_mem[alloc_slot] <= aq_desc.port;
    end
  end

  // alloc and cmpl never target the same slot
  always_ff @(posedge clk) begin
    if (alloc) hndl_mem[alloc_slot] <= aq_desc.hndl;
    if (cmpl_vld) hndl_mem[cmpl.slot] <= cmpl.hndl;  // consumer may rewrite the handle
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NS; i++) begin
        done[i] <= '0;
      end
    end else begin
      if (alloc) done[alloc_slot] <= '0;
      if (cmpl_vld) done[cmpl.slot] <= done[cmpl.slot] + 1'b1;
    end
  end

  assign alloc_nstg = aq_desc.nstg;

  // program entry for the stage about to run
  assign disp_cons = prog_mem[disp_slot][disp_stg];
  assign disp_hndl = hndl_mem[disp_slot];

  assign retire_port = port_mem[retire_slot];

  always_comb begin
    retire_item.slot = retire_slot;
    retire_item.hndl = hndl_mem[retire_slot];
    retire_item.stg  = done[retire_slot];
  end

endmodule

`default_nettype wire

// File: src/dispatch_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "pifo_settings.svh"

module dispatch_queue (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire                                  disp_go,
  input  wire pifo_pkg::disp_t                 disp_item,
  output logic [`PIFO_CONS-1:0]                disp_free,
  output logic [`PIFO_CONS-1:0]                p_vld,
  output pifo_pkg::disp_t [`PIFO_CONS-1:0]     p_item,
  input  wire [`PIFO_CONS-1:0]                 p_bp
);

  localparam int NC = `PIFO_CONS;

  logic [NC-1:0] load;

  always_comb begin
    for (int c = 0; c < NC; c++) begin
      load[c] = disp_go && (disp_item.cons == pifo_pkg::cons_t'(c));
    end
  end

  // free also when the current item leaves this cycle
  assign disp_free = ~p_vld | ~p_bp;

  always_ff @(posedge clk) begin
    for (int c = 0; c < NC; c++) begin
      if (load[c]) p_item[c] <= disp_item;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      p_vld <= '0;
    end else begin
      for (int c = 0; c < NC; c++) begin
        if (load[c]) p_vld[c] <= 1'b1;
        else if (!p_bp[c]) p_vld[c] <= 1'b0;  // taken by the consumer
      end
    end
  end

endmodule

`default_nettype wire

// File: src/egress_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "pifo_settings.svh"

module egress_queue (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire                              ret_go,
  input  wire pifo_pkg::port_t             retire_port,
  input  wire pifo_pkg::egr_t              retire_item,
  output logic [`PIFO_PORTS-1:0]           egr_free,
  output logic [`PIFO_PORTS-1:0]           x_vld,
  output pifo_pkg::egr_t [`PIFO_PORTS-1:0] x_item,
  input  wire [`PIFO_PORTS-1:0]            x_bp
);

  localparam int NP = `PIFO_PORTS;

  logic [NP-1:0] load;

  always_comb begin
    for (int x = 0; x < NP; x++) begin
      load[x] = ret_go && (retire_port == pifo_pkg::port_t'(x));
    end
  end

  assign egr_free = ~x_vld | ~x_bp;

  always_ff @(posedge clk) begin
    for (int x = 0; x < NP; x++) begin
      if (load[x]) x_item[x] <= retire_item;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      x_vld <= '0;
    end else begin
      for (int x = 0; x < NP; x++) begin
        if (load[x]) x_vld[x] <= 1'b1;
        else if (!x_bp[x]) x_vld[x] <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/pifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "pifo_settings.svh"

module pifo (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire                                  ar_push,
  input  wire pifo_pkg::desc_t                 ar_dat,
  output wire                                  ar_bp,
  output wire [`PIFO_CONS-1:0]                 p_vld,
  output wire pifo_pkg::disp_t [`PIFO_CONS-1:0] p_item,
  input  wire [`PIFO_CONS-1:0]                 p_bp,
  input  wire [`PIFO_CONS-1:0]                 r_vld,
  input  wire pifo_pkg::ret_t [`PIFO_CONS-1:0] r_item,
  output wire [`PIFO_CONS-1:0]                 r_bp,
  output wire [`PIFO_PORTS-1:0]                x_vld,
  output wire pifo_pkg::egr_t [`PIFO_PORTS-1:0] x_item,
  input  wire [`PIFO_PORTS-1:0]                x_bp
);

  wire                         aq_vld;
  wire pifo_pkg::desc_t        aq_desc;
  wire                         alloc;
  wire pifo_pkg::slot_t        alloc_slot;
  wire pifo_pkg::stg_t         alloc_nstg;
  wire [`PIFO_CONS-1:0]        disp_free;
  wire                         disp_go;
  wire pifo_pkg::slot_t        disp_slot;
  wire pifo_pkg::cons_t        disp_cons;
  wire pifo_pkg::stg_t         disp_stg;
  wire pifo_pkg::hndl_t        disp_hndl;
  wire pifo_pkg::disp_t        disp_item;
  wire                         cmpl_vld;
  wire pifo_pkg::ret_t         cmpl;
  wire [`PIFO_PORTS-1:0]       egr_free;
  wire                         ret_go;
  wire pifo_pkg::slot_t        retire_slot;
  wire pifo_pkg::port_t        retire_port;
  wire pifo_pkg::egr_t         retire_item;

  // work item toward a consumer
  assign disp_item = '{slot: disp_slot, cons: disp_cons, stg: disp_stg, hndl: disp_hndl};

  arrival_queue i_aq (
    .clk(clk), .rst_n(rst_n),
    .ar_push(ar_push), .ar_dat(ar_dat), .ar_bp(ar_bp),
    .aq_vld(aq_vld), .aq_desc(aq_desc), .alloc(alloc)
  );

  slot_arbiter i_arb (
    .clk(clk), .rst_n(rst_n),
    .aq_vld(aq_vld), .alloc(alloc), .alloc_slot(alloc_slot), .aq_nstg(alloc_nstg),
    .disp_free(disp_free), .disp_go(disp_go), .disp_slot(disp_slot),
    .disp_cons(disp_cons), .disp_stg(disp_stg),
    .cmpl_vld(cmpl_vld), .cmpl_slot(cmpl.slot),
    .egr_free(egr_free), .ret_go(ret_go), .retire_slot(retire_slot),
    .retire_port(retire_port)
  );

  context_mem i_cm (
    .clk(clk), .rst_n(rst_n),
    .alloc(alloc), .alloc_slot(alloc_slot), .aq_desc(aq_desc),
    .disp_slot(disp_slot), .disp_stg(disp_stg), .disp_cons(disp_cons), .disp_hndl(disp_hndl),
    .cmpl_vld(cmpl_vld), .cmpl(cmpl),
    .retire_slot(retire_slot), .retire_item(retire_item), .retire_port(retire_port),
    .alloc_nstg(alloc_nstg)
  );

  dispatch_queue i_dq (
    .clk(clk), .rst_n(rst_n),
    .disp_go(disp_go), .disp_item(disp_item), .disp_free(disp_free),
    .p_vld(p_vld), .p_item(p_item), .p_bp(p_bp)
  );

  completion_merge i_cmrg (
    .clk(clk), .rst_n(rst_n),
    .r_vld(r_vld), .r_item(r_item), .r_bp(r_bp),
    .cmpl_vld(cmpl_vld), .cmpl(cmpl)
  );

  egress_queue i_eq (
    .clk(clk), .rst_n(rst_n),
    .ret_go(ret_go), .retire_port(retire_port), .retire_item(retire_item),
    .egr_free(egr_free), .x_vld(x_vld), .x_item(x_item), .x_bp(x_bp)
  );

endmodule

`default_nettype wire

// File: src/pifo_pkg.sv
`default_nettype none
`include "pifo_settings.svh"

package pifo_pkg;

  localparam int SLOT_W = (`PIFO_SLOTS > 1) ? $clog2(`PIFO_SLOTS) : 1;
  localparam int CONS_W = (`PIFO_CONS > 1) ? $clog2(`PIFO_CONS) : 1;
  localparam int PORT_W = (`PIFO_PORTS > 1) ? $clog2(`PIFO_PORTS) : 1;
  localparam int STG_W  = $clog2(`PIFO_STGS + 1);  // holds 0 up to a full program

  typedef logic [SLOT_W-1:0]       slot_t;
  typedef logic [CONS_W-1:0]       cons_t;
  typedef logic [PORT_W-1:0]       port_t;
  typedef logic [STG_W-1:0]        stg_t;
  typedef logic [`PIFO_HNDL_W-1:0] hndl_t;

  typedef enum logic [1:0] {
    SLOT_FREE,
    SLOT_WAIT,  // ready for the next stage
    SLOT_BUSY,  // sitting at a consumer
    SLOT_DONE
  } slot_state_t;

  // arrival word, prog[0] is the first consumer
  typedef struct packed {
    hndl_t                       hndl;
    port_t                       port;
    stg_t                        nstg;
    cons_t [`PIFO_STGS-1:0]      prog;
  } desc_t;

  typedef struct packed {
    slot_t slot;
    cons_t cons;
    stg_t  stg;   // stage index being run
    hndl_t hndl;
  } disp_t;

  typedef struct packed {
    slot_t slot;
    hndl_t hndl;
  } ret_t;

  typedef struct packed {
    slot_t slot;
    hndl_t hndl;
    stg_t  stg;   // stages completed
  } egr_t;

endpackage

`default_nettype wire

// File: src/slot_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "pifo_settings.svh"

module slot_arbiter (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    aq_vld,
  output logic                   alloc,
  output pifo_pkg::slot_t        alloc_slot,
  input  wire pifo_pkg::stg_t    aq_nstg,
  input  wire [`PIFO_CONS-1:0]   disp_free,
  output logic                   disp_go,
  output pifo_pkg::slot_t        disp_slot,
  input  wire pifo_pkg::cons_t   disp_cons,
  output pifo_pkg::stg_t         disp_stg,
  input  wire                    cmpl_vld,
  input  wire pifo_pkg::slot_t   cmpl_slot,
  input  wire [`PIFO_PORTS-1:0]  egr_free,
  output logic                   ret_go,
  output pifo_pkg::slot_t        retire_slot,
  input  wire pifo_pkg::port_t   retire_port
);

  localparam int NS = `PIFO_SLOTS;

  pifo_pkg::slot_state_t state [NS];
  pifo_pkg::stg_t        stg_cnt [NS];  // stages done so far
  pifo_pkg::stg_t        nstg [NS];
  pifo_pkg::slot_t       tail;          // next slot to allocate
  pifo_pkg::slot_t       head;          // oldest packet, retires first
  pifo_pkg::slot_t       rr_ptr;
  pifo_pkg::stg_t        cmpl_stg;
  logic                  wait_any;

  function automatic pifo_pkg::slot_t slot_next(input pifo_pkg::slot_t s);
    return (int'(s) == NS - 1) ? '0 : s + 1'b1;
  endfunction

  // ring order means a free tail is the only free slot that matters
  assign alloc      = aq_vld && (state[tail] == pifo_pkg::SLOT_FREE);
  assign alloc_slot = tail;

  assign retire_slot = head;
  assign ret_go      = (state[head] == pifo_pkg::SLOT_DONE) && egr_free[retire_port];

  // round robin over waiting slots, lowest offset from rr_ptr wins
  always_comb begin : disp_pick
    int idx;
    disp_slot = rr_ptr;
    wait_any  = 1'b0;
    for (int i = NS - 1; i >= 0; i--) begin
      idx = (int'(rr_ptr) + i) % NS;
      if (state[idx] == pifo_pkg::SLOT_WAIT) begin
        disp_slot = pifo_pkg::slot_t'(idx);
        wait_any  = 1'b1;
      end
    end
  end

  assign disp_stg = stg_cnt[disp_slot];
  assign disp_go  = wait_any && disp_free[disp_cons];  // disp_cons comes back from context_mem
  assign cmpl_stg = stg_cnt[cmpl_slot] + 1'b1;

  always_ff @(posedge clk) begin
    if (alloc) nstg[tail] <= aq_nstg;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NS; i++) begin
        state[i]   <= pifo_pkg::SLOT_FREE;
        stg_cnt[i] <= '0;
      end
      tail   <= '0;
      head   <= '0;
      rr_ptr <= '0;
    end else begin
      if (alloc) begin
        state[tail]   <= pifo_pkg::SLOT_WAIT;
        stg_cnt[tail] <= '0;
        tail          <= slot_next(tail);
      end
      // move on even when the pick is blocked, so others get a turn
      if (wait_any) rr_ptr <= slot_next(disp_slot);
      if (disp_go) state[disp_slot] <= pifo_pkg::SLOT_BUSY;
      if (cmpl_vld) begin
        stg_cnt[cmpl_slot] <= cmpl_stg;
        if (cmpl_stg == nstg[cmpl_slot]) state[cmpl_slot] <= pifo_pkg::SLOT_DONE;
        else state[cmpl_slot] <= pifo_pkg::SLOT_WAIT;
      end
      if (ret_go) begin
        state[head] <= pifo_pkg::SLOT_FREE;
        head        <= slot_next(head);
      end
    end
  end

endmodule

`default_nettype wire

// File: test/pifo_props.sv
`timescale 1ns/1ps
`default_nettype none
`include "pifo_settings.svh"

module pifo_props (
  input wire                                  clk,
  input wire                                  rst_n,
  input wire                                  ar_bp,
  input wire [`PIFO_CONS-1:0]                 p_vld,
  input wire pifo_pkg::disp_t [`PIFO_CONS-1:0] p_item,
  input wire [`PIFO_CONS-1:0]                 p_bp,
  input wire [`PIFO_CONS-1:0]                 r_vld,
  input wire pifo_pkg::ret_t [`PIFO_CONS-1:0]  r_item,
  input wire [`PIFO_CONS-1:0]                 r_bp,
  input wire [`PIFO_PORTS-1:0]                x_vld,
  input wire pifo_pkg::egr_t [`PIFO_PORTS-1:0] x_item,
  input wire [`PIFO_PORTS-1:0]                x_bp
);

  logic [`PIFO_SLOTS-1:0] outstanding;  // slots handed to a consumer

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= '0;
    end else begin
      for (int c = 0; c < `PIFO_CONS; c++) begin
        if (p_vld[c] && !p_bp[c]) outstanding[p_item[c].slot] <= 1'b1;
        if (r_vld[c] && !r_bp[c]) outstanding[r_item[c].slot] <= 1'b0;
      end
    end
  end

  a_bp_in_reset: assert property (@(posedge clk) !rst_n |-> !ar_bp)
    else $error("ar_bp high during reset");

  for (genvar c = 0; c < `PIFO_CONS; c++) begin : g_cons
    a_p_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (p_vld[c] && p_bp[c]) |=> (p_vld[c] && $stable(p_item[c])))
      else $error("dispatch item changed while stalled");
    // a return must match a slot that is really out
    a_r_known: assert property (@(posedge clk) disable iff (!rst_n)
      r_vld[c] |-> outstanding[r_item[c].slot])
      else $error("return for a slot that was never dispatched");
  end

  for (genvar x = 0; x < `PIFO_PORTS; x++) begin : g_port
    a_x_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (x_vld[x] && x_bp[x]) |=> (x_vld[x] && $stable(x_item[x])))
      else $error("egress item changed while stalled");
  end

endmodule

`default_nettype wire

// File: test/pifo_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "pifo_settings.svh"

module pifo_tb;

  localparam int NC = `PIFO_CONS;
  localparam int NP = `PIFO_PORTS;
  localparam int NS = `PIFO_SLOTS;
  localparam int MAX_SEQ = 256;
  localparam int MAX_CYCLES = 4000;  // ~90 packets at no more than ~40 cycles each
  localparam int FILL = `PIFO_SLOTS + `PIFO_AQ_DEPTH + 1;  // slots, fifo, held port reg

  logic                          clk = 1'b0;
  logic                          rst_n;
  logic                          ar_push;
  pifo_pkg::desc_t               ar_dat;
  wire                           ar_bp;
  wire [NC-1:0]                  p_vld;
  wire pifo_pkg::disp_t [NC-1:0] p_item;
  logic [NC-1:0]                 p_bp;
  logic [NC-1:0]                 r_vld;
  pifo_pkg::ret_t [NC-1:0]       r_item;
  wire [NC-1:0]                  r_bp;
  wire [NP-1:0]                  x_vld;
  wire pifo_pkg::egr_t [NP-1:0]  x_item;
  logic [NP-1:0]                 x_bp;

  string           cur_test;
  int              errs;
  int              errs_at_start;
  int              tests_run;
  int              tests_failed;
  int              cycles = 0;
  logic [31:0]     rng = 32'd66;
  int              cons_delay [NC];
  logic [NC-1:0]   p_hold;      // forced consumer stall
  logic [NP-1:0]   x_hold;      // forced port stall
  logic            rand_mode;   // random delays and back-pressure

  // bookkeeping per packet, indexed by arrival number
  pifo_pkg::desc_t seq_desc [MAX_SEQ];
  pifo_pkg::egr_t  exp_egr [MAX_SEQ];
  pifo_pkg::hndl_t seq_hndl [MAX_SEQ];
  int              seq_done [MAX_SEQ];  // stages returned so far
  int              slot_gen [NS];       // packets finished per slot
  int              push_cnt;
  int              exp_q [$];           // arrival numbers not yet out

  pifo i_dut (.*);

  bind pifo pifo_props i_props (
    .clk(clk), .rst_n(rst_n), .ar_bp(ar_bp),
    .p_vld(p_vld), .p_item(p_item), .p_bp(p_bp),
    .r_vld(r_vld), .r_item(r_item), .r_bp(r_bp),
    .x_vld(x_vld), .x_item(x_item), .x_bp(x_bp)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // slots are taken in ring order from 0, so the resident packet follows
  function automatic int slot_seq(input pifo_pkg::slot_t s);
    return slot_gen[s] * NS + int'(s);
  endfunction

  function automatic pifo_pkg::desc_t make_desc(input int h, input int port, input int nstg,
                                                input int c0, input int c1, input int c2);
    pifo_pkg::desc_t d;
    d.hndl    = pifo_pkg::hndl_t'(h);
    d.port    = pifo_pkg::port_t'(port);
    d.nstg    = pifo_pkg::stg_t'(nstg);
    d.prog    = '0;
    d.prog[0] = pifo_pkg::cons_t'(c0);
    d.prog[1] = pifo_pkg::cons_t'(c1);
    d.prog[2] = pifo_pkg::cons_t'(c2);
    return d;
  endfunction

  task automatic check_equal(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("mismatch in %s, %s: expected %0h actual %0h", cur_test, what, exp, act);
      errs++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test      = name;
    errs_at_start = errs;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errs == errs_at_start) begin
      $display("test %s passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", cur_test, errs - errs_at_start);
    end
  endtask

  // entered and left one step after a clock edge
  task automatic push_desc(input pifo_pkg::desc_t d);
    pifo_pkg::egr_t e;
    int seq;
    ar_dat  = d;
    ar_push = 1'b1;
    do @(posedge clk); while (ar_bp);
    seq = push_cnt;
    push_cnt++;
    seq_desc[seq] = d;
    seq_done[seq] = 0;
    seq_hndl[seq] = d.hndl;
    e.slot = pifo_pkg::slot_t'(seq % NS);
    e.hndl = d.hndl;
    for (int k = 0; k < int'(d.nstg); k++) begin
      e.hndl = e.hndl + pifo_pkg::hndl_t'(int'(d.prog[k]) + 1);  // each core adds id+1
    end
    e.stg = d.nstg;
    exp_egr[seq] = e;
    exp_q.push_back(seq);
    #1 ar_push = 1'b0;
  endtask

  task automatic wait_all_out();
    do @(posedge clk); while (exp_q.size() != 0);
    #1;
  endtask

  task automatic note_dispatch(input int c, input pifo_pkg::disp_t item);
    int seq;
    seq = slot_seq(item.slot);
    check_equal("dispatch consumer", 32'(c), 32'(item.cons));
    check_equal("dispatch stage", 32'(seq_done[seq]), 32'(item.stg));
    check_equal("program entry", 32'(seq_desc[seq].prog[seq_done[seq]]), 32'(item.cons));
    check_equal("dispatch handle", 32'(seq_hndl[seq]), 32'(item.hndl));
  endtask

  task automatic note_return(input int c, input pifo_pkg::slot_t slot);
    int seq;
    seq = slot_seq(slot);
    seq_done[seq]++;
    seq_hndl[seq] = seq_hndl[seq] + pifo_pkg::hndl_t'(c + 1);
    if (seq_done[seq] == int'(seq_desc[seq].nstg)) slot_gen[slot]++;
  endtask

  // oldest queued packet for this port must be the one leaving
  task automatic check_egress(input int x, input pifo_pkg::egr_t got);
    int pos;
    pos = -1;
    for (int i = 0; i < exp_q.size(); i++) begin
      if (pos < 0 && int'(seq_desc[exp_q[i]].port) == x) pos = i;
    end
    assert (pos >= 0) else begin
      $display("packet %0h left port %0d in test %s but none was expected", got, x, cur_test);
      errs++;
    end
    if (pos >= 0) begin
      check_equal("egress item", 32'(exp_egr[exp_q[pos]]), 32'(got));
      exp_q.delete(pos);
    end
  endtask

  initial begin : consumer_model
    pifo_pkg::ret_t [NC-1:0] ret_nxt;
    logic [NC-1:0]           vld_nxt;
    logic [NC-1:0]           busy;
    int                      cnt [NC];
    logic [31:0]             r;
    busy    = '0;
    vld_nxt = '0;
    ret_nxt = '0;
    p_bp    = '0;
    r_vld   = '0;
    r_item  = '0;
    for (int c = 0; c < NC; c++) cnt[c] = 0;
    forever begin
      @(posedge clk);
      for (int c = 0; c < NC; c++) begin
        if (r_vld[c] && !r_bp[c]) begin
          note_return(c, r_item[c].slot);
          vld_nxt[c] = 1'b0;
          busy[c]    = 1'b0;
        end
        if (p_vld[c] && !p_bp[c]) begin
          note_dispatch(c, p_item[c]);
          ret_nxt[c].slot = p_item[c].slot;
          ret_nxt[c].hndl = p_item[c].hndl + pifo_pkg::hndl_t'(c + 1);
          busy[c] = 1'b1;
          cnt[c]  = rand_mode ? int'(xorshift32() % 32'd6) : cons_delay[c];
        end else if (busy[c] && !vld_nxt[c]) begin
          if (cnt[c] == 0) vld_nxt[c] = 1'b1;
          else cnt[c]--;
        end
      end
      #1;
      r_vld  = vld_nxt;
      r_item = ret_nxt;
      for (int c = 0; c < NC; c++) begin
        r = xorshift32();
        p_bp[c] = busy[c] | p_hold[c] | (rand_mode & (r[1:0] == 2'b00));  // one item per core
      end
    end
  end

  initial begin : port_model
    logic [31:0] r;
    x_bp = '0;
    forever begin
      @(posedge clk);
      for (int x = 0; x < NP; x++) begin
        if (x_vld[x] && !x_bp[x]) check_egress(x, x_item[x]);
      end
      #1;
      for (int x = 0; x < NP; x++) begin
        r = xorshift32();
        x_bp[x] = x_hold[x] | (rand_mode & (r[1:0] == 2'b00));
      end
    end
  end

  initial begin : watchdog
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run passed %0d cycles in test %s", MAX_CYCLES, cur_test);
    $display("=== FAIL ===");
    $finish;
  end

  task automatic single_stage();
    start_test("single_stage");
    push_desc(make_desc(16'h1000, 0, 1, 2, 0, 0));
    wait_all_out();
    finish_test();
  endtask

  task automatic three_stage_order();
    int seq;
    start_test("three_stage_order");
    push_desc(make_desc(16'h2000, 1, 3, 3, 0, 1));
    seq = push_cnt - 1;
    wait_all_out();
    check_equal("stages visited", 32'd3, 32'(seq_done[seq]));
    finish_test();
  endtask

  task automatic slow_then_fast();
    start_test("slow_then_fast");
    cons_delay[0] = 24;  // early packets finish last
    for (int i = 0; i < 3; i++) push_desc(make_desc(16'h3000 + i, 0, 1, 0, 0, 0));
    for (int i = 0; i < 5; i++) push_desc(make_desc(16'h3100 + i, 0, 1, 1 + i % 3, 0, 0));
    wait_all_out();
    cons_delay[0] = 1;
    finish_test();
  endtask

  task automatic egress_backpressure();
    int n;
    int first;
    start_test("egress_backpressure");
    first = push_cnt;
    x_hold[0] = 1'b1;
    for (int i = 0; i < FILL; i++) push_desc(make_desc(16'h4000 + i, 0, 1, i % NC, 0, 0));
    n = 0;
    while (!ar_bp && n < 100) begin
      @(posedge clk);
      #1;
      n++;
    end
    assert (ar_bp) else begin
      $display("ar_bp never rose while port 0 was stalled in test %s", cur_test);
      errs++;
    end
    // oldest packet sits in the stalled port register
    check_equal("stalled port valid", 32'd1, 32'(x_vld[0]));
    check_equal("stalled port item", 32'(exp_egr[first]), 32'(x_item[0]));
    x_hold[0] = 1'b0;
    wait_all_out();
    finish_test();
  endtask

  task automatic consumer_backpressure();
    int sa;
    int sb;
    int sc;
    int n;
    start_test("consumer_backpressure");
    p_hold[2] = 1'b1;
    push_desc(make_desc(16'h5000, 1, 1, 2, 0, 0));
    sa = push_cnt - 1;
    push_desc(make_desc(16'h5100, 1, 2, 0, 1, 0));
    sb = push_cnt - 1;
    push_desc(make_desc(16'h5200, 0, 1, 3, 0, 0));
    sc = push_cnt - 1;
    n = 0;
    while (!(seq_done[sb] == 2 && seq_done[sc] == 1) && n < 200) begin
      @(posedge clk);
      #1;
      n++;
    end
    check_equal("stages on free cores", 32'd3, 32'(seq_done[sb] + seq_done[sc]));
    check_equal("stalled core valid", 32'd1, 32'(p_vld[2]));
    check_equal("stalled core slot", 32'(sa % NS), 32'(p_item[2].slot));
    check_equal("packets held behind head", 32'd3, 32'(exp_q.size()));
    p_hold[2] = 1'b0;
    wait_all_out();
    finish_test();
  endtask

  task automatic random_traffic();
    int nstg;
    int gap;
    start_test("random_traffic");
    rand_mode = 1'b1;
    for (int i = 0; i < 60; i++) begin
      nstg = 1 + int'(xorshift32() % 32'(`PIFO_STGS));
      push_desc(make_desc(int'(xorshift32() % 32'h10000), int'(xorshift32() % 32'(NP)), nstg,
                          int'(xorshift32() % 32'(NC)), int'(xorshift32() % 32'(NC)),
                          int'(xorshift32() % 32'(NC))));
      gap = int'(xorshift32() % 32'd3);
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
    end
    wait_all_out();
    rand_mode = 1'b0;
    finish_test();
  endtask

  initial begin : main_seq
    rst_n        = 1'b0;
    ar_push      = 1'b0;
    ar_dat       = '0;
    p_hold       = '0;
    x_hold       = '0;
    rand_mode    = 1'b0;
    errs         = 0;
    tests_run    = 0;
    tests_failed = 0;
    push_cnt     = 0;
    cur_test     = "reset";
    for (int c = 0; c < NC; c++) cons_delay[c] = 1;
    for (int s = 0; s < NS; s++) slot_gen[s] = 0;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    @(posedge clk);
    #1;
    single_stage();
    three_stage_order();
    slow_then_fast();
    egress_backpressure();
    consumer_backpressure();
    random_traffic();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errs);
    if (errs == 0 && tests_failed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
